//--- hw/fg_config_pkg.sv
package fg_config_pkg;

	// bits in one waveform word, also the serializer ratio
	localparam int sample_width = 8;

	// waveform RAM addressing
	localparam int address_width = 6;
	// one revolution of playback
	localparam int ram_depth = 64;

	// pulse-width pattern puts one pulse every this many addresses
	localparam int pulse_period = 8;

	// LFSR size and start value
	localparam int prbs_width = 16;
	localparam logic [prbs_width-1:0] prbs_seed = 16'hace1;

	// serializer bit index, counts 0 to sample_width-1
	localparam int bit_count_width = 3;

endpackage

//--- hw/fg_types_pkg.sv
package fg_types_pkg;

	// one waveform word
	typedef logic [fg_config_pkg::sample_width-1:0] sample_t;

	// one waveform RAM address
	typedef logic [fg_config_pkg::address_width-1:0] address_t;

	// waveform selected by a command
	typedef enum logic [1:0] {
		ramp = 2'd0,
		pilot = 2'd1,
		pulse_width = 2'd2,
		prbs = 2'd3
	} pattern_t;

	// top-level control FSM
	typedef enum logic [1:0] {
		idle = 2'd0,
		load = 2'd1,
		play = 2'd2
	} control_state_t;

endpackage

//--- hw/fg_control.sv
module fg_control (
	input logic clock,
	input logic reset,
	input logic cmd_valid,
	input fg_types_pkg::pattern_t cmd_pattern,
	input fg_types_pkg::address_t cmd_marker,
	output logic cmd_ready,
	output logic load_start,
	output fg_types_pkg::pattern_t load_pattern,
	output fg_types_pkg::address_t load_marker,
	input logic load_done,
	output logic play_enable
);

	fg_types_pkg::control_state_t state;
	logic accept;

	// commands are refused only while the RAM is being filled
	assign cmd_ready = (state != fg_types_pkg::load);
	assign accept = cmd_valid && cmd_ready;

	// playback runs for as long as we sit in play
	assign play_enable = (state == fg_types_pkg::play);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fg_types_pkg::idle;
			load_start <= 1'b0;
		end else begin
			// one-cycle kick to the writer, the cycle after acceptance
			load_start <= accept;
			case (state)
				fg_types_pkg::idle, fg_types_pkg::play: begin
					// a command in play also aborts playback
					if (accept) begin
						state <= fg_types_pkg::load;
					end
				end
				fg_types_pkg::load: begin
					if (load_done) begin
						state <= fg_types_pkg::play;
					end
				end
				default: begin
					state <= fg_types_pkg::idle;
				end
			endcase
		end
	end

	// accepted command, held for the writer through the whole load
	always_ff @(posedge clock) begin
		if (accept) begin
			load_pattern <= cmd_pattern;
			load_marker <= cmd_marker;
		end
	end

	// writer must only finish a load that we started
	load_done_in_load: assert property (
		@(posedge clock) disable iff (reset)
		load_done |-> (state == fg_types_pkg::load)
	);

endmodule

//--- hw/pattern_writer.sv
module pattern_writer (
	input logic clock,
	input logic reset,
	input logic load_start,
	input fg_types_pkg::pattern_t load_pattern,
	input fg_types_pkg::address_t load_marker,
	output logic load_done,
	output logic prbs_restart,
	output logic prbs_advance,
	input fg_types_pkg::sample_t prbs_word,
	output logic write_enable,
	output fg_types_pkg::address_t write_address,
	output fg_types_pkg::sample_t write_data
);

	fg_types_pkg::pattern_t pattern_q;
	fg_types_pkg::address_t marker_q;
	fg_types_pkg::pattern_t pattern_now;
	fg_types_pkg::address_t marker_now;
	fg_types_pkg::address_t count;
	logic active;
	logic [fg_config_pkg::bit_count_width:0] pulse_ones;

	// address 0 goes out in the load_start cycle itself
	assign pattern_now = load_start ? load_pattern : pattern_q;
	assign marker_now = load_start ? load_marker : marker_q;

	assign write_enable = load_start || active;
	assign write_address = count;
	assign load_done = active && (count == fg_types_pkg::address_t'(fg_config_pkg::ram_depth - 1));

	// LFSR steps after every prbs word, and rewinds to the seed once a load ends
	assign prbs_advance = write_enable && (pattern_now == fg_types_pkg::prbs);
	assign prbs_restart = load_done;

	// 1 to 8 ones, growing with the top address bits
	assign pulse_ones = (fg_config_pkg::bit_count_width + 1)'(count / fg_config_pkg::pulse_period)
		+ 1'b1;

	always_comb begin
		write_data = '0;
		case (pattern_now)
			fg_types_pkg::ramp: begin
				write_data = fg_types_pkg::sample_t'(count);
			end
			fg_types_pkg::pilot: begin
				// single full word at the marker
				if (count == marker_now) begin
					write_data = '1;
				end
			end
			fg_types_pkg::pulse_width: begin
				// thermometer code from the msb down
				if ((count % fg_config_pkg::pulse_period) == 0) begin
					write_data = ~(fg_types_pkg::sample_t'('1) >> pulse_ones);
				end
			end
			fg_types_pkg::prbs: begin
				write_data = prbs_word;
			end
			default: begin
				write_data = '0;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
			count <= '0;
		end else if (load_start) begin
			active <= 1'b1;
			count <= fg_types_pkg::address_t'(1);
		end else if (load_done) begin
			active <= 1'b0;
			count <= '0;
		end else if (active) begin
			count <= count + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (load_start) begin
			pattern_q <= load_pattern;
			marker_q <= load_marker;
		end
	end

	// one pass over the RAM, never a second lap
	write_burst_bounded: assert property (
		@(posedge clock) disable iff (reset)
		$rose(write_enable) |-> ##[1:fg_config_pkg::ram_depth] !write_enable
	);

endmodule

//--- hw/prbs_generator.sv
module prbs_generator (
	input logic clock,
	input logic reset,
	input logic restart,
	input logic advance,
	output fg_types_pkg::sample_t word
);

	logic [fg_config_pkg::prbs_width-1:0] lfsr;
	logic feedback;

	// taps 16 14 13 11, fibonacci form
	assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	// low byte is what gets written to the RAM
	assign word = lfsr[fg_config_pkg::sample_width-1:0];

	always_ff @(posedge clock) begin
		if (reset) begin
			lfsr <= fg_config_pkg::prbs_seed;
		end else if (restart) begin
			// restart wins over a step in the same cycle
			lfsr <= fg_config_pkg::prbs_seed;
		end else if (advance) begin
			// shift left, new bit into bit 0
			lfsr <= {lfsr[fg_config_pkg::prbs_width-2:0], feedback};
		end
	end

endmodule

//--- hw/waveform_ram.sv
module waveform_ram (
	input logic clock,
	input logic write_enable,
	input fg_types_pkg::address_t write_address,
	input fg_types_pkg::sample_t write_data,
	input fg_types_pkg::address_t read_address,
	output fg_types_pkg::sample_t read_data
);

	// block RAM style storage, contents undefined until the first load
	fg_types_pkg::sample_t memory [fg_config_pkg::ram_depth];

	// write port
	always_ff @(posedge clock) begin
		if (write_enable) begin
			memory[write_address] <= write_data;
		end
	end

	// registered read, data one cycle after the address
	always_ff @(posedge clock) begin
		read_data <= memory[read_address];
	end

endmodule

//--- hw/playback_sequencer.sv
module playback_sequencer (
	input logic clock,
	input logic reset,
	input logic play_enable,
	output fg_types_pkg::address_t read_address,
	input fg_types_pkg::sample_t read_data,
	output fg_types_pkg::sample_t word_data,
	output logic word_valid,
	output logic word_first,
	input logic word_ready
);

	fg_types_pkg::address_t address;
	// read_data holds the word at address
	logic fetched;
	logic stage_free;
	logic capture;

	assign read_address = address;
	assign stage_free = !word_valid || word_ready;
	assign capture = fetched && stage_free;

	always_ff @(posedge clock) begin
		if (reset || !play_enable) begin
			address <= '0;
			fetched <= 1'b0;
			word_valid <= 1'b0;
		end else if (capture) begin
			// loop back to 0 after the last word
			if (address == fg_types_pkg::address_t'(fg_config_pkg::ram_depth - 1)) begin
				address <= '0;
			end else begin
				address <= address + 1'b1;
			end
			// new address needs one more cycle through the RAM
			fetched <= 1'b0;
			word_valid <= 1'b1;
		end else begin
			// address held while stalled, so read_data stays good
			fetched <= 1'b1;
			if (word_ready) begin
				word_valid <= 1'b0;
			end
		end
	end

	// output stage
	always_ff @(posedge clock) begin
		if (capture) begin
			word_data <= read_data;
			word_first <= (address == '0);
		end
	end

	// serializer sees a steady word while it is busy
	word_held_on_stall: assert property (
		@(posedge clock) disable iff (reset)
		(word_valid && !word_ready) |=> $stable(word_data)
	);

endmodule

//--- hw/word_serializer.sv
module word_serializer (
	input logic clock,
	input logic reset,
	input fg_types_pkg::sample_t word_data,
	input logic word_valid,
	input logic word_first,
	output logic word_ready,
	output logic bit_out,
	output logic frame_start
);

	fg_types_pkg::sample_t shift_reg;
	logic [fg_config_pkg::bit_count_width-1:0] bit_index;
	logic busy;
	logic first_q;
	logic last_bit;
	logic take;

	assign last_bit = (bit_index == fg_config_pkg::bit_count_width'(fg_config_pkg::sample_width - 1));

	// next word is loaded on the last bit, so the stream has no gaps
	assign word_ready = !busy || last_bit;
	assign take = word_valid && word_ready;

	// msb first, idle low
	assign bit_out = busy && shift_reg[fg_config_pkg::sample_width-1];

	// marks bit 7 of address 0
	assign frame_start = busy && first_q && (bit_index == '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			first_q <= 1'b0;
			bit_index <= '0;
		end else if (take) begin
			busy <= 1'b1;
			first_q <= word_first;
			bit_index <= '0;
		end else if (busy) begin
			bit_index <= bit_index + 1'b1;
			// ran dry, nothing waiting
			if (last_bit) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			shift_reg <= word_data;
		end else begin
			shift_reg <= shift_reg << 1;
		end
	end

endmodule

//--- hw/function_generator.sv
module function_generator (
	input logic clock,
	input logic reset,
	input logic cmd_valid,
	input fg_types_pkg::pattern_t cmd_pattern,
	input fg_types_pkg::address_t cmd_marker,
	output logic cmd_ready,
	output logic bit_out,
	output logic frame_start,
	output logic playing
);

	// control to writer
	logic load_start;
	fg_types_pkg::pattern_t load_pattern;
	fg_types_pkg::address_t load_marker;
	logic load_done;
	logic play_enable;

	// writer to LFSR
	logic prbs_restart;
	logic prbs_advance;
	fg_types_pkg::sample_t prbs_word;

	// RAM ports
	logic write_enable;
	fg_types_pkg::address_t write_address;
	fg_types_pkg::sample_t write_data;
	fg_types_pkg::address_t read_address;
	fg_types_pkg::sample_t read_data;

	// word stream into the serializer
	fg_types_pkg::sample_t word_data;
	logic word_valid;
	logic word_ready;
	logic word_first;
	logic serializer_reset;

	assign playing = play_enable;
	// stopping playback flushes the shifter
	assign serializer_reset = reset || !play_enable;

	fg_control control (
		.clock(clock),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_pattern(cmd_pattern),
		.cmd_marker(cmd_marker),
		.cmd_ready(cmd_ready),
		.load_start(load_start),
		.load_pattern(load_pattern),
		.load_marker(load_marker),
		.load_done(load_done),
		.play_enable(play_enable)
	);

	pattern_writer writer (
		.clock(clock),
		.reset(reset),
		.load_start(load_start),
		.load_pattern(load_pattern),
		.load_marker(load_marker),
		.load_done(load_done),
		.prbs_restart(prbs_restart),
		.prbs_advance(prbs_advance),
		.prbs_word(prbs_word),
		.write_enable(write_enable),
		.write_address(write_address),
		.write_data(write_data)
	);

	prbs_generator prbs (
		.clock(clock),
		.reset(reset),
		.restart(prbs_restart),
		.advance(prbs_advance),
		.word(prbs_word)
	);

	waveform_ram ram (
		.clock(clock),
		.write_enable(write_enable),
		.write_address(write_address),
		.write_data(write_data),
		.read_address(read_address),
		.read_data(read_data)
	);

	playback_sequencer sequencer (
		.clock(clock),
		.reset(reset),
		.play_enable(play_enable),
		.read_address(read_address),
		.read_data(read_data),
		.word_data(word_data),
		.word_valid(word_valid),
		.word_first(word_first),
		.word_ready(word_ready)
	);

	word_serializer serializer (
		.clock(clock),
		.reset(serializer_reset),
		.word_data(word_data),
		.word_valid(word_valid),
		.word_first(word_first),
		.word_ready(word_ready),
		.bit_out(bit_out),
		.frame_start(frame_start)
	);

endmodule

//--- include/fg_tb_checks.svh
`ifndef FG_TB_CHECKS_SVH
`define FG_TB_CHECKS_SVH

// two full revolutions is more than any startup latency
localparam int frame_timeout = 2 * fg_config_pkg::ram_depth * fg_config_pkg::sample_width;
// a load takes one pass over the RAM
localparam int ready_timeout = 4 * fg_config_pkg::ram_depth;

// print the reason, then stop the run
task automatic abort_run(input string reason);
	$display("%s", reason);
	$display("test failed");
	$fatal(1);
endtask

task automatic check_word(
	input fg_types_pkg::sample_t actual,
	input fg_types_pkg::sample_t expected,
	input string what
);
	if (actual !== expected) begin
		abort_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h",
			$time, what, actual, expected));
	end
endtask

task automatic check_flag(input logic actual, input logic expected, input string what);
	if (actual !== expected) begin
		abort_run($sformatf("MISMATCH at %0t ns: %s is %b, expected %b",
			$time, what, actual, expected));
	end
endtask

task automatic check_count(input int actual, input int expected, input string what);
	if (actual != expected) begin
		abort_run($sformatf("MISMATCH at %0t ns: %s is %0d, expected %0d",
			$time, what, actual, expected));
	end
endtask

// returns on the cycle where frame_start is high
task automatic wait_frame_start();
	int waited;
	waited = 0;
	while (frame_start !== 1'b1) begin
		if (waited >= frame_timeout) begin
			abort_run($sformatf("timeout at %0t ns: no frame_start while playing", $time));
		end
		next_cycle();
		waited++;
	end
endtask

// returns on a cycle where a command would be taken
task automatic wait_ready();
	int waited;
	waited = 0;
	while (cmd_ready !== 1'b1) begin
		if (waited >= ready_timeout) begin
			abort_run($sformatf("timeout at %0t ns: cmd_ready stayed low", $time));
		end
		next_cycle();
		waited++;
	end
endtask

`endif

//--- test/function_generator_tb.sv
module function_generator_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic clock;
	logic reset;
	logic cmd_valid;
	fg_types_pkg::pattern_t cmd_pattern;
	fg_types_pkg::address_t cmd_marker;
	logic cmd_ready;
	logic bit_out;
	logic frame_start;
	logic playing;

	// free running cycle count for interval checks
	int cycles;
	logic [31:0] rng_state;
	// one revolution as seen on bit_out
	fg_types_pkg::sample_t frame [fg_config_pkg::ram_depth];

	function_generator DUT (
		.clock(clock),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_pattern(cmd_pattern),
		.cmd_marker(cmd_marker),
		.cmd_ready(cmd_ready),
		.bit_out(bit_out),
		.frame_start(frame_start),
		.playing(playing)
	);

	`include "fg_tb_checks.svh"

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
	end

	// drive and sample point just after the edge
	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic idle_cycles(input int count);
		int i;
		for (i = 0; i < count; i++) begin
			next_cycle();
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// expected RAM word for one address
	function automatic fg_types_pkg::sample_t model_word(
		input fg_types_pkg::pattern_t pattern,
		input int address,
		input int marker
	);
		fg_types_pkg::sample_t word;
		logic [15:0] lfsr;
		logic tap;
		int ones;
		int step;
		word = '0;
		case (pattern)
			fg_types_pkg::ramp: begin
				word = fg_types_pkg::sample_t'(address);
			end
			fg_types_pkg::pilot: begin
				if (address == marker) begin
					word = '1;
				end
			end
			fg_types_pkg::pulse_width: begin
				// thermometer with one more bit per pulse
				if (address % fg_config_pkg::pulse_period == 0) begin
					ones = address / fg_config_pkg::pulse_period + 1;
					for (step = 0; step < ones; step++) begin
						word[fg_config_pkg::sample_width - 1 - step] = 1'b1;
					end
				end
			end
			default: begin
				// taps 16 14 13 11 with one step per earlier address
				lfsr = fg_config_pkg::prbs_seed;
				for (step = 0; step < address; step++) begin
					tap = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
					lfsr = {lfsr[14:0], tap};
				end
				word = lfsr[7:0];
			end
		endcase
		return word;
	endfunction

	task automatic send_command(
		input fg_types_pkg::pattern_t pattern,
		input fg_types_pkg::address_t marker
	);
		wait_ready();
		cmd_valid = 1'b1;
		cmd_pattern = pattern;
		cmd_marker = marker;
		next_cycle();
		cmd_valid = 1'b0;
	endtask

	// from the cycle after acceptance until playing rises
	task automatic finish_load();
		int load_cycles;
		load_cycles = 0;
		while (playing !== 1'b1) begin
			check_flag(cmd_ready, 1'b0, "cmd_ready during load");
			// shifter may still show its last bit in the first cycle
			if (load_cycles > 0) begin
				check_flag(bit_out, 1'b0, "bit_out during load");
				check_flag(frame_start, 1'b0, "frame_start during load");
			end
			if (load_cycles >= ready_timeout) begin
				abort_run($sformatf("timeout at %0t ns: playing never rose", $time));
			end
			next_cycle();
			load_cycles++;
		end
		check_count(load_cycles, fg_config_pkg::ram_depth, "load cycles");
		check_flag(cmd_ready, 1'b1, "cmd_ready in play");
	endtask

	// 64 words from bit_out msb first starting at frame_start
	task automatic capture_frame(output int start_cycle);
		fg_types_pkg::sample_t word;
		int w;
		int b;
		wait_frame_start();
		start_cycle = cycles;
		for (w = 0; w < fg_config_pkg::ram_depth; w++) begin
			word = '0;
			for (b = 0; b < fg_config_pkg::sample_width; b++) begin
				check_flag(frame_start, (w == 0) && (b == 0), "frame_start");
				word = {word[fg_config_pkg::sample_width-2:0], bit_out};
				next_cycle();
			end
			frame[w] = word;
		end
	endtask

	task automatic check_frame(
		input fg_types_pkg::pattern_t pattern,
		input fg_types_pkg::address_t marker
	);
		int a;
		for (a = 0; a < fg_config_pkg::ram_depth; a++) begin
			check_word(frame[a], model_word(pattern, a, int'(marker)),
				$sformatf("%s word %0d", pattern.name(), a));
		end
	endtask

	task automatic test_reset_state();
		check_flag(cmd_ready, 1'b1, "cmd_ready after reset");
		check_flag(playing, 1'b0, "playing after reset");
		check_flag(bit_out, 1'b0, "bit_out after reset");
		check_flag(frame_start, 1'b0, "frame_start after reset");
	endtask

	task automatic test_ramp();
		int first;
		int second;
		send_command(fg_types_pkg::ramp, '0);
		finish_load();
		capture_frame(first);
		check_frame(fg_types_pkg::ramp, '0);
		// second lap must be identical and back to back
		capture_frame(second);
		check_frame(fg_types_pkg::ramp, '0);
		check_count(second - first, fg_config_pkg::ram_depth * fg_config_pkg::sample_width,
			"frame_start interval");
	endtask

	task automatic test_pilot();
		fg_types_pkg::address_t marker;
		int start;
		rng_state = xorshift32(rng_state);
		marker = rng_state[fg_config_pkg::address_width-1:0];
		send_command(fg_types_pkg::pilot, marker);
		finish_load();
		capture_frame(start);
		check_frame(fg_types_pkg::pilot, marker);
	endtask

	task automatic test_pulse_width();
		int start;
		send_command(fg_types_pkg::pulse_width, '0);
		finish_load();
		capture_frame(start);
		check_frame(fg_types_pkg::pulse_width, '0);
	endtask

	task automatic test_prbs();
		int start;
		send_command(fg_types_pkg::prbs, '0);
		finish_load();
		capture_frame(start);
		check_frame(fg_types_pkg::prbs, '0);
	endtask

	// abort prbs playback somewhere inside a word
	task automatic test_reload();
		int start;
		rng_state = xorshift32(rng_state);
		idle_cycles(3 + int'(rng_state[4:0]));
		check_flag(playing, 1'b1, "playing before reload");
		send_command(fg_types_pkg::ramp, '0);
		check_flag(playing, 1'b0, "playing after reload");
		finish_load();
		capture_frame(start);
		check_frame(fg_types_pkg::ramp, '0);
	endtask

	initial begin
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_pattern = fg_types_pkg::ramp;
		cmd_marker = '0;
		rng_state = 32'd6017;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		test_reset_state();
		test_ramp();
		test_pilot();
		test_pulse_width();
		test_prbs();
		test_reload();
		$display("test passed");
		$finish;
	end

endmodule

//--- sim.f
+incdir+include
hw/fg_config_pkg.sv
hw/fg_types_pkg.sv
hw/fg_control.sv
hw/pattern_writer.sv
hw/prbs_generator.sv
hw/waveform_ram.sv
hw/playback_sequencer.sv
hw/word_serializer.sv
hw/function_generator.sv
test/function_generator_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP = function_generator_tb
FILELIST = sim.f
BUILD_DIR = obj_dir
PASS_TEXT = test passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the pass line shows up in the run output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
